// ==== frontend_pkg.sv ====
`default_nettype none

package frontend_pkg;

    localparam int XLEN       = 32;  // Data and address width
    localparam int REG_ADDR_W = 5;   // 32 general purpose registers

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;

    // 74x381 function select, alu_op[2:0]
    localparam logic [2:0] ALU_CLR   = 3'd0;
    localparam logic [2:0] ALU_BSUBA = 3'd1;  // B minus A
    localparam logic [2:0] ALU_SUB   = 3'd2;  // A minus B
    localparam logic [2:0] ALU_ADD   = 3'd3;
    localparam logic [2:0] ALU_XOR   = 3'd4;
    localparam logic [2:0] ALU_OR    = 3'd5;
    localparam logic [2:0] ALU_AND   = 3'd6;
    localparam logic [2:0] ALU_SET   = 3'd7;

    // One-hot flags in alu_op[7:3]
    localparam int ALU_SLT_BIT  = 7;
    localparam int ALU_SLTU_BIT = 6;
    localparam int ALU_SLL_BIT  = 5;
    localparam int ALU_SRL_BIT  = 4;
    localparam int ALU_SRA_BIT  = 3;

    // One-hot memory access codes in mem_op
    localparam int MEM_SW  = 7;
    localparam int MEM_SH  = 6;
    localparam int MEM_SB  = 5;
    localparam int MEM_LHU = 4;
    localparam int MEM_LBU = 3;
    localparam int MEM_LW  = 2;
    localparam int MEM_LH  = 1;
    localparam int MEM_LB  = 0;

    // The same instruction word seen through every base format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm_11_0;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_11_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_4_0;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm_12;
            logic [5:0] imm_10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm_4_1;
            logic       imm_11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm_31_12;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm_20;
            logic [9:0] imm_10_1;
            logic       imm_11;
            logic [7:0] imm_19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_t;

endpackage

`default_nettype wire

// ==== branch_if.sv ====
`default_nettype none

interface branch_if;

    logic                          is_jal;
    logic                          is_jalr;
    logic                          is_branch;
    logic [2:0]                    funct3;  // Branch condition select
    logic [frontend_pkg::XLEN-1:0] j_imm;
    logic [frontend_pkg::XLEN-1:0] b_imm;
    logic [frontend_pkg::XLEN-1:0] i_imm;   // Jalr offset

    modport decoder (
        output is_jal, is_jalr, is_branch, funct3, j_imm, b_imm, i_imm
    );

    modport fetch (
        input is_jal, is_jalr, is_branch, funct3, j_imm, b_imm, i_imm
    );

endinterface

`default_nettype wire

// ==== gpr_if.sv ====
`default_nettype none

interface gpr_if;

    logic [frontend_pkg::REG_ADDR_W-1:0] ra;  // Port a address, rs1
    logic [frontend_pkg::REG_ADDR_W-1:0] rb;  // Port b address, rs2
    logic [frontend_pkg::REG_ADDR_W-1:0] rd;
    logic                                we;
    logic [frontend_pkg::XLEN-1:0]       qa;
    logic [frontend_pkg::XLEN-1:0]       qb;

    modport decoder (output ra, rb, rd, we, input qa, qb);

    modport regfile (input ra, rb, rd, we, output qa, qb);

    // Jalr takes its base address from port a
    modport fetch (input qa);

endinterface

`default_nettype wire

// ==== fetch_unit.sv ====
`default_nettype none

module fetch_unit #(
    parameter logic [frontend_pkg::XLEN-1:0] RESET_ADDR = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    branch_if.fetch                       br,
    gpr_if.fetch                          gpr,
    input  logic                          is_zero,  // rs1 equals rs2
    input  logic                          is_lt,
    input  logic                          is_ltu,
    output logic [frontend_pkg::XLEN-1:0] pc
);

    logic                          taken;
    logic [frontend_pkg::XLEN-1:0] pc_base;
    logic [frontend_pkg::XLEN-1:0] pc_offs;
    logic [frontend_pkg::XLEN-1:0] pc_sum;
    logic [frontend_pkg::XLEN-1:0] next_pc;

    always_comb begin
        case (br.funct3)
            3'd0:    taken = is_zero;   // beq
            3'd1:    taken = ~is_zero;  // bne
            3'd4:    taken = is_lt;     // blt
            3'd5:    taken = ~is_lt;    // bge
            3'd6:    taken = is_ltu;    // bltu
            3'd7:    taken = ~is_ltu;   // bgeu
            default: taken = 1'b0;
        endcase
    end

    // One adder serves every target, only base and offset change
    assign pc_base = br.is_jalr ? gpr.qa : pc;

    always_comb begin
        if (br.is_jal)                      pc_offs = br.j_imm;
        else if (br.is_jalr)                pc_offs = br.i_imm;
        else if (br.is_branch && taken)     pc_offs = br.b_imm;
        else                                pc_offs = frontend_pkg::XLEN'(4);
    end

    assign pc_sum  = pc_base + pc_offs;
    assign next_pc = br.is_jalr ? {pc_sum[frontend_pkg::XLEN-1:1], 1'b0} : pc_sum;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_ADDR;
        end else begin
            pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== inst_decoder.sv ====
`default_nettype none

module inst_decoder (
    input  frontend_pkg::rv_inst_t        inst,
    input  logic [frontend_pkg::XLEN-1:0] pc,
    branch_if.decoder                     br,
    gpr_if.decoder                        gpr,
    output logic [7:0]                    alu_op,  // Flags in [7:3], 74x381 code in [2:0]
    output logic [7:0]                    mem_op,
    output logic                          load,
    output logic                          store,
    output logic [frontend_pkg::XLEN-1:0] alu_opr_1,
    output logic [frontend_pkg::XLEN-1:0] alu_opr_2
);

    localparam int XLEN = frontend_pkg::XLEN;

    logic            is_lui;
    logic            is_auipc;
    logic            is_jal;
    logic            is_jalr;
    logic            is_branch;
    logic            is_imm;
    logic            is_reg;
    logic [2:0]      funct3;
    logic [XLEN-1:0] i_imm;
    logic [XLEN-1:0] s_imm;
    logic [XLEN-1:0] b_imm;
    logic [XLEN-1:0] u_imm;
    logic [XLEN-1:0] j_imm;

    assign is_lui    = inst.r.opcode == frontend_pkg::OPC_LUI;
    assign is_auipc  = inst.r.opcode == frontend_pkg::OPC_AUIPC;
    assign is_jal    = inst.r.opcode == frontend_pkg::OPC_JAL;
    assign is_jalr   = inst.r.opcode == frontend_pkg::OPC_JALR;
    assign is_branch = inst.r.opcode == frontend_pkg::OPC_BRANCH;
    assign is_imm    = inst.r.opcode == frontend_pkg::OPC_IMM;
    assign is_reg    = inst.r.opcode == frontend_pkg::OPC_REG;
    assign load      = inst.r.opcode == frontend_pkg::OPC_LOAD;
    assign store     = inst.r.opcode == frontend_pkg::OPC_STORE;
    assign funct3    = inst.r.funct3;

    // Sign extended immediates gathered from each format view
    assign i_imm = {{(XLEN-12){inst.i.imm_11_0[11]}}, inst.i.imm_11_0};
    assign s_imm = {{(XLEN-12){inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
    assign b_imm = {{(XLEN-12){inst.b.imm_12}}, inst.b.imm_11, inst.b.imm_10_5,
                    inst.b.imm_4_1, 1'b0};
    assign u_imm = {inst.u.imm_31_12, 12'b0};
    assign j_imm = {{(XLEN-20){inst.j.imm_20}}, inst.j.imm_19_12, inst.j.imm_11,
                    inst.j.imm_10_1, 1'b0};

    assign br.is_jal    = is_jal;
    assign br.is_jalr   = is_jalr;
    assign br.is_branch = is_branch;
    assign br.funct3    = inst.b.funct3;
    assign br.j_imm     = j_imm;
    assign br.b_imm     = b_imm;
    assign br.i_imm     = i_imm;

    assign gpr.ra = inst.r.rs1;
    assign gpr.rb = inst.r.rs2;
    assign gpr.rd = inst.r.rd;
    assign gpr.we = is_lui | is_auipc | is_jal | is_jalr | load | is_imm | is_reg;

    always_comb begin
        alu_op = {5'b0, frontend_pkg::ALU_ADD};  // Address and link arithmetic
        if (is_branch) begin
            alu_op[2:0] = frontend_pkg::ALU_SUB;  // Flags come from rs1 - rs2
        end else if (is_reg || is_imm) begin
            case (funct3)
                3'd0: alu_op[2:0] = (is_reg && inst.r.funct7[5]) ? frontend_pkg::ALU_SUB
                                                                  : frontend_pkg::ALU_ADD;
                3'd1: begin
                    alu_op[frontend_pkg::ALU_SLL_BIT] = 1'b1;
                    alu_op[2:0] = frontend_pkg::ALU_CLR;
                end
                3'd2: begin
                    alu_op[frontend_pkg::ALU_SLT_BIT] = 1'b1;
                    alu_op[2:0] = frontend_pkg::ALU_SUB;
                end
                3'd3: begin
                    alu_op[frontend_pkg::ALU_SLTU_BIT] = 1'b1;
                    alu_op[2:0] = frontend_pkg::ALU_SUB;
                end
                3'd4: alu_op[2:0] = frontend_pkg::ALU_XOR;
                3'd5: begin
                    // Bit 30 picks arithmetic shift in both forms
                    if (inst.r.funct7[5]) alu_op[frontend_pkg::ALU_SRA_BIT] = 1'b1;
                    else                  alu_op[frontend_pkg::ALU_SRL_BIT] = 1'b1;
                    alu_op[2:0] = frontend_pkg::ALU_CLR;
                end
                3'd6: alu_op[2:0] = frontend_pkg::ALU_OR;
                default: alu_op[2:0] = frontend_pkg::ALU_AND;
            endcase
        end
    end

    always_comb begin
        mem_op = '0;
        if (load) begin
            case (funct3)
                3'd0:    mem_op[frontend_pkg::MEM_LB]  = 1'b1;
                3'd1:    mem_op[frontend_pkg::MEM_LH]  = 1'b1;
                3'd2:    mem_op[frontend_pkg::MEM_LW]  = 1'b1;
                3'd4:    mem_op[frontend_pkg::MEM_LBU] = 1'b1;
                3'd5:    mem_op[frontend_pkg::MEM_LHU] = 1'b1;
                default: mem_op = '0;
            endcase
        end else if (store) begin
            case (funct3)
                3'd0:    mem_op[frontend_pkg::MEM_SB] = 1'b1;
                3'd1:    mem_op[frontend_pkg::MEM_SH] = 1'b1;
                3'd2:    mem_op[frontend_pkg::MEM_SW] = 1'b1;
                default: mem_op = '0;
            endcase
        end
    end

    always_comb begin
        alu_opr_1 = gpr.qa;  // Register and branch compare
        alu_opr_2 = gpr.qb;
        if (is_lui) begin
            alu_opr_1 = '0;
            alu_opr_2 = u_imm;
        end else if (is_auipc) begin
            alu_opr_1 = pc;
            alu_opr_2 = u_imm;
        end else if (is_jal || is_jalr) begin
            alu_opr_1 = pc;  // Link address pc + 4
            alu_opr_2 = XLEN'(4);
        end else if (load || is_imm) begin
            alu_opr_2 = i_imm;
        end else if (store) begin
            alu_opr_2 = s_imm;
        end
    end

endmodule

`default_nettype wire

// ==== gpr_file.sv ====
`default_nettype none

module gpr_file (
    input  logic                          clk,
    input  logic                          rst_n,
    gpr_if.regfile                        gpr,
    input  logic [frontend_pkg::XLEN-1:0] gpr_di  // Result from ALU or memory
);

    localparam int NREGS = 2 ** frontend_pkg::REG_ADDR_W;

    logic [frontend_pkg::XLEN-1:0] regs [1:NREGS-1];  // x0 has no storage

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (gpr.we && gpr.rd != '0) begin
            regs[gpr.rd] <= gpr_di;
        end
    end

    // x0 always reads as zero
    assign gpr.qa = (gpr.ra == '0) ? '0 : regs[gpr.ra];
    assign gpr.qb = (gpr.rb == '0) ? '0 : regs[gpr.rb];

endmodule

`default_nettype wire

// ==== frontend.sv ====
`default_nettype none

module frontend #(
    parameter logic [frontend_pkg::XLEN-1:0] RESET_ADDR = '0
) (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic [frontend_pkg::XLEN-1:0] pc,         // Instruction fetch address
    input  logic [frontend_pkg::XLEN-1:0] inst,       // Returned in the same cycle
    output logic [7:0]                    alu_op,
    output logic [7:0]                    mem_op,     // sw sh sb lhu lbu lw lh lb
    output logic                          load,
    output logic                          store,
    output logic [frontend_pkg::XLEN-1:0] alu_opr_1,
    output logic [frontend_pkg::XLEN-1:0] alu_opr_2,
    output logic [frontend_pkg::XLEN-1:0] mem_di,     // Store data from rs2
    input  logic [frontend_pkg::XLEN-1:0] gpr_di,     // Write back data for rd
    input  logic                          is_lt,
    input  logic                          is_ltu,
    input  logic                          is_zero
);

    branch_if br_bus ();
    gpr_if    gpr_bus ();

    fetch_unit #(
        .RESET_ADDR (RESET_ADDR)
    ) u_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .br      (br_bus.fetch),
        .gpr     (gpr_bus.fetch),
        .is_zero (is_zero),
        .is_lt   (is_lt),
        .is_ltu  (is_ltu),
        .pc      (pc)
    );

    inst_decoder u_decoder (
        .inst      (inst),
        .pc        (pc),
        .br        (br_bus.decoder),
        .gpr       (gpr_bus.decoder),
        .alu_op    (alu_op),
        .mem_op    (mem_op),
        .load      (load),
        .store     (store),
        .alu_opr_1 (alu_opr_1),
        .alu_opr_2 (alu_opr_2)
    );

    gpr_file u_gpr (
        .clk    (clk),
        .rst_n  (rst_n),
        .gpr    (gpr_bus.regfile),
        .gpr_di (gpr_di)
    );

    assign mem_di = gpr_bus.qb;

endmodule

`default_nettype wire

// ==== tb_frontend.sv ====
`default_nettype none

module tb_frontend;

    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] RESET_ADDR     = 32'h0000_0100;
    localparam logic [31:0] NOP            = 32'h0000_0013;  // addi x0, x0, 0
    localparam int          MAX_RECORDS    = 256;
    localparam int          MAX_TEXT_LINES = 512;

    logic        clk;
    logic        rst_n;
    logic [31:0] pc;
    logic [31:0] inst;
    logic [7:0]  alu_op;
    logic [7:0]  mem_op;
    logic        load;
    logic        store;
    logic [31:0] alu_opr_1;
    logic [31:0] alu_opr_2;
    logic [31:0] mem_di;
    logic [31:0] gpr_di;
    logic        is_lt;
    logic        is_ltu;
    logic        is_zero;

    integer           fd;
    int               rec_num;
    bit               found;
    logic [8*256-1:0] text;
    logic [31:0]      rec [0:12];  // Stimulus 0..4, expected outputs 5..12

    frontend #(
        .RESET_ADDR (RESET_ADDR)
    ) dut0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .pc        (pc),
        .inst      (inst),
        .alu_op    (alu_op),
        .mem_op    (mem_op),
        .load      (load),
        .store     (store),
        .alu_opr_1 (alu_opr_1),
        .alu_opr_2 (alu_opr_2),
        .mem_di    (mem_di),
        .gpr_di    (gpr_di),
        .is_lt     (is_lt),
        .is_ltu    (is_ltu),
        .is_zero   (is_zero)
    );

    always #2 clk = ~clk;  // 4 ns period

    task automatic abort_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[FAIL] record %0d %s: got 0x%h, expected 0x%h",
                     rec_num, name, actual, expected);
            abort_run();
        end
    endtask

    // Skips comment and blank lines, returns the next full record
    task automatic next_record(output bit ok);
        int n;
        int cnt;
        ok = 1'b0;
        for (int i = 0; i < MAX_TEXT_LINES && !ok; i++) begin
            if ($feof(fd)) break;
            text = '0;
            n = $fgets(text, fd);
            if (n > 0) begin
                cnt = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                              rec[0], rec[1], rec[2], rec[3], rec[4], rec[5], rec[6],
                              rec[7], rec[8], rec[9], rec[10], rec[11], rec[12]);
                if (cnt == 13) begin
                    ok = 1'b1;
                end else if (cnt > 0) begin
                    $display("Trace line after record %0d has %0d fields instead of 13",
                             rec_num, cnt);
                    abort_run();
                end
            end
        end
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst        = NOP;
        gpr_di      = '0;
        is_lt       = 1'b0;
        is_ltu      = 1'b0;
        is_zero     = 1'b0;
        rec_num     = 0;
        found       = 1'b0;

        fd = $fopen("frontend_trace.txt", "r");
        if (fd == 0) begin
            $display("Could not open the trace file frontend_trace.txt");
            abort_run();
        end

        for (int c = 0; c < 8; c++) begin  // Reset held for 8 cycles
            @(posedge clk);
        end
        check_value("pc in reset", pc, RESET_ADDR);
        #1;
        rst_n = 1'b1;

        // First record is driven together with the reset release
        for (rec_num = 0; rec_num < MAX_RECORDS; rec_num++) begin
            next_record(found);
            if (!found) break;
            if (rec_num > 0) begin
                @(posedge clk);
                #1;
            end
            inst    = rec[0];
            gpr_di  = rec[1];
            is_lt   = rec[2][0];
            is_ltu  = rec[3][0];
            is_zero = rec[4][0];
            #2;  // Outputs settled 3 ns after the edge
            check_value("pc", pc, rec[5]);
            check_value("alu_op", alu_op, rec[6]);
            check_value("mem_op", mem_op, rec[7]);
            check_value("load", load, rec[8]);
            check_value("store", store, rec[9]);
            check_value("alu_opr_1", alu_opr_1, rec[10]);
            check_value("alu_opr_2", alu_opr_2, rec[11]);
            check_value("mem_di", mem_di, rec[12]);
        end
        $fclose(fd);

        if (rec_num == 0) begin
            $display("The trace file holds no records");
            abort_run();
        end
        if (found) begin
            $display("The replay limit of %0d records was reached before the trace ended",
                     MAX_RECORDS);
            abort_run();
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

`default_nettype wire

// ==== frontend_trace.txt ====
# inst gpr_di is_lt is_ltu is_zero | expected: pc alu_op mem_op load store alu_opr_1 alu_opr_2 mem_di
# One record per cycle, all hex, rows 0..44 from reset address 0x100
00500093 00000005 0 0 0 00000100 03 00 0 0 00000000 00000005 00000000
12345137 12345000 0 0 0 00000104 03 00 0 0 00000000 12345000 00000000
00001197 00001108 0 0 0 00000108 03 00 0 0 00000108 00001000 00000000
00108013 deadbeef 0 0 0 0000010c 03 00 0 0 00000005 00000001 00000005
00308233 0000110d 0 0 0 00000110 03 00 0 0 00000005 00001108 00001108
400102b3 12345000 0 0 0 00000114 02 00 0 0 12345000 00000000 00000000
00122533 00000000 0 0 0 00000118 82 00 0 0 0000110d 00000005 00000005
00123533 00000000 0 0 0 0000011c 42 00 0 0 0000110d 00000005 00000005
00121533 000221a0 0 0 0 00000120 20 00 0 0 0000110d 00000005 00000005
00125533 00000088 0 0 0 00000124 10 00 0 0 0000110d 00000005 00000005
40125533 00000088 0 0 0 00000128 08 00 0 0 0000110d 00000005 00000005
00124533 00001108 0 0 0 0000012c 04 00 0 0 0000110d 00000005 00000005
00126533 0000110d 0 0 0 00000130 05 00 0 0 0000110d 00000005 00000005
00127533 00000005 0 0 0 00000134 06 00 0 0 0000110d 00000005 00000005
ffd22593 00000000 0 0 0 00000138 82 00 0 0 0000110d fffffffd 00000000
10023593 00000000 0 0 0 0000013c 42 00 0 0 0000110d 00000100 00000000
00321593 00008868 0 0 0 00000140 20 00 0 0 0000110d 00000003 00001108
00225593 00000443 0 0 0 00000144 10 00 0 0 0000110d 00000002 12345000
40425593 00000110 0 0 0 00000148 08 00 0 0 0000110d 00000404 0000110d
0ff24593 000011f2 0 0 0 0000014c 04 00 0 0 0000110d 000000ff 00000000
01026593 0000111d 0 0 0 00000150 05 00 0 0 0000110d 00000010 00000000
f0f27593 0000110d 0 0 0 00000154 06 00 0 0 0000110d ffffff0f 00000000
00418603 ffffff80 0 0 0 00000158 03 01 1 0 00001108 00000004 0000110d
ffe19603 ffff8001 0 0 0 0000015c 03 02 1 0 00001108 fffffffe 00000000
0081a603 cafef00d 0 0 0 00000160 03 04 1 0 00001108 00000008 00000000
0011c603 00000080 0 0 0 00000164 03 08 1 0 00001108 00000001 00000005
7fe1d603 00008001 0 0 0 00000168 03 10 1 0 00001108 000007fe 00000000
001181a3 bad00000 0 0 0 0000016c 03 20 0 1 00001108 00000003 00000005
fe419e23 bad00001 0 0 0 00000170 03 40 0 1 00001108 fffffffc 0000110d
0421a023 bad00002 0 0 0 00000174 03 80 0 1 00001108 00000040 12345000
00408863 55555555 0 0 1 00000178 02 00 0 0 00000005 0000110d 0000110d
00408863 55555555 1 1 0 00000188 02 00 0 0 00000005 0000110d 0000110d
00409463 55555555 0 0 0 0000018c 02 00 0 0 00000005 0000110d 0000110d
00409463 55555555 0 1 1 00000194 02 00 0 0 00000005 0000110d 0000110d
fe40c0e3 55555555 1 0 0 00000198 02 00 0 0 00000005 0000110d 0000110d
fe40c0e3 55555555 0 1 1 00000178 02 00 0 0 00000005 0000110d 0000110d
0040d863 55555555 0 1 0 0000017c 02 00 0 0 00000005 0000110d 0000110d
0040d863 55555555 1 0 1 0000018c 02 00 0 0 00000005 0000110d 0000110d
0040e463 55555555 0 1 0 00000190 02 00 0 0 00000005 0000110d 0000110d
0040e463 55555555 1 0 1 00000198 02 00 0 0 00000005 0000110d 0000110d
0040f863 55555555 1 0 0 0000019c 02 00 0 0 00000005 0000110d 0000110d
0040f863 55555555 0 1 1 000001ac 02 00 0 0 00000005 0000110d 0000110d
040006ef 000001b4 0 0 0 000001b0 03 00 0 0 000001b0 00000004 00000000
10008767 000001f4 0 0 0 000001f0 03 00 0 0 000001f0 00000004 00000000
01018033 77777777 0 0 0 00000104 03 00 0 0 00001108 00000000 00000000

// ==== frontend.f ====
frontend_pkg.sv
branch_if.sv
gpr_if.sv
fetch_unit.sv
inst_decoder.sv
gpr_file.sv
frontend.sv
tb_frontend.sv

// ==== Bender.yml ====
package:
  name: frontend

sources:
  - frontend_pkg.sv
  - branch_if.sv
  - gpr_if.sv
  - fetch_unit.sv
  - inst_decoder.sv
  - gpr_file.sv
  - frontend.sv
  - target: test
    files:
      - tb_frontend.sv
